/* logic/riscv_isa_pkg.sv */
// RV64I instruction-set encodings and base types
package riscv_isa_pkg;

    localparam int xlen      = 64;
    localparam int reg_count = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    // inst[6:0]
    typedef enum logic [6:0] {
        opc_load      = 7'b0000011,
        opc_op_imm    = 7'b0010011,
        opc_auipc     = 7'b0010111,
        opc_op_imm_32 = 7'b0011011,
        opc_store     = 7'b0100011,
        opc_op        = 7'b0110011,
        opc_lui       = 7'b0110111,
        opc_op_32     = 7'b0111011,
        opc_branch    = 7'b1100011,
        opc_jalr      = 7'b1100111,
        opc_jal       = 7'b1101111
    } major_opcode_e;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;  // sub and arithmetic shifts

endpackage

/* logic/decode_pkg.sv */
// decode-stage vocabulary: operations, ALU modes and operand sources
package decode_pkg;

    typedef enum logic [5:0] {
        op_none,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_addiw, op_slliw, op_srliw, op_sraiw,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd
    } dec_op_e;

    // execute-side encoding, 5 is unused
    typedef enum logic [7:0] {
        alu_add  = 8'd0,
        alu_sub  = 8'd1,
        alu_slt  = 8'd2,
        alu_sltu = 8'd3,
        alu_and  = 8'd4,
        alu_or   = 8'd6,
        alu_xor  = 8'd7,
        alu_sll  = 8'd8,
        alu_srl  = 8'd9,
        alu_sra  = 8'd10
    } alu_mode_e;

    typedef enum logic [1:0] {
        opa_zero,
        opa_src1,
        opa_src1_low_zext,
        opa_src1_low_high
    } opa_sel_e;

    typedef enum logic [3:0] {
        opb_zero,
        opb_src2,
        opb_src2_sh6,
        opb_src2_sh5,
        opb_imm_i,
        opb_imm_s,
        opb_imm_u,
        opb_imm_j,
        opb_shamt6,
        opb_shamt5
    } opb_sel_e;

endpackage

/* logic/id_stage_ctrl.sv */
// decode stage register with scoreboard hazard check and valid/ready control
`timescale 1ns/1ps

module id_stage_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid_IF_ID,
    input  riscv_isa_pkg::word_t      pc_IF_ID,
    input  riscv_isa_pkg::inst_t      inst_IF_ID,
    input  logic                      ready_ID_EX,
    input  logic [riscv_isa_pkg::reg_count-1:0] gpr_busy,
    input  riscv_isa_pkg::reg_idx_t   rs1,
    input  riscv_isa_pkg::reg_idx_t   rs2,
    input  logic                      uses_rs1,
    input  logic                      uses_rs2,
    output logic                      stage_valid,
    output riscv_isa_pkg::word_t      stage_pc,
    output riscv_isa_pkg::inst_t      stage_inst,
    output logic                      ready_IF_ID,
    output logic                      valid_ID_EX
);

    logic hazard;
    logic stall;

    // source still owned by an older instruction
    assign hazard = (uses_rs1 && gpr_busy[rs1]) || (uses_rs2 && gpr_busy[rs2]);

    // held item waits on a hazard or on execute back-pressure
    assign stall       = stage_valid && (hazard || !ready_ID_EX);
    assign ready_IF_ID = !stall;
    assign valid_ID_EX = stage_valid && !hazard;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (!stall) begin
            stage_valid <= valid_IF_ID;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_pc   <= pc_IF_ID;
            stage_inst <= inst_IF_ID;
        end
    end

endmodule

/* logic/inst_decoder.sv */
// instruction decoder: operation, register fields, write enable and source use
`timescale 1ns/1ps

module inst_decoder (
    input  logic                      stage_valid,
    input  riscv_isa_pkg::inst_t      stage_inst,
    output decode_pkg::dec_op_e       op,
    output riscv_isa_pkg::reg_idx_t   rd,
    output riscv_isa_pkg::reg_idx_t   rs1,
    output riscv_isa_pkg::reg_idx_t   rs2,
    output logic                      wen,
    output logic                      uses_rs1,
    output logic                      uses_rs2
);
    import riscv_isa_pkg::*;
    import decode_pkg::*;

    major_opcode_e opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;

    assign opcode = major_opcode_e'(stage_inst[6:0]);
    assign funct3 = stage_inst[14:12];
    assign funct7 = stage_inst[31:25];
    assign rd     = stage_inst[11:7];
    assign rs1    = stage_inst[19:15];
    assign rs2    = stage_inst[24:20];

    always_comb begin
        op = op_none;
        if (stage_valid) begin
            case (opcode)
                opc_op: begin
                    case ({funct7, funct3})
                        {funct7_base, 3'b000}: op = op_add;
                        {funct7_alt,  3'b000}: op = op_sub;
                        {funct7_base, 3'b001}: op = op_sll;
                        {funct7_base, 3'b010}: op = op_slt;
                        {funct7_base, 3'b011}: op = op_sltu;
                        {funct7_base, 3'b100}: op = op_xor;
                        {funct7_base, 3'b101}: op = op_srl;
                        {funct7_alt,  3'b101}: op = op_sra;
                        {funct7_base, 3'b110}: op = op_or;
                        {funct7_base, 3'b111}: op = op_and;
                    endcase
                end
                opc_op_imm: begin
                    case (funct3)
                        3'b000: op = op_addi;
                        3'b010: op = op_slti;
                        3'b011: op = op_sltiu;
                        3'b100: op = op_xori;
                        3'b110: op = op_ori;
                        3'b111: op = op_andi;
                    endcase
                    // bit 25 belongs to the 6-bit shamt
                    case ({funct7[6:1], funct3})
                        {funct7_base[6:1], 3'b001}: op = op_slli;
                        {funct7_base[6:1], 3'b101}: op = op_srli;
                        {funct7_alt[6:1],  3'b101}: op = op_srai;
                    endcase
                end
                opc_op_32: begin
                    case ({funct7, funct3})
                        {funct7_base, 3'b000}: op = op_addw;
                        {funct7_alt,  3'b000}: op = op_subw;
                        {funct7_base, 3'b001}: op = op_sllw;
                        {funct7_base, 3'b101}: op = op_srlw;
                        {funct7_alt,  3'b101}: op = op_sraw;
                    endcase
                end
                opc_op_imm_32: begin
                    if (funct3 == 3'b000) begin
                        op = op_addiw;
                    end
                    case ({funct7, funct3})
                        {funct7_base, 3'b001}: op = op_slliw;
                        {funct7_base, 3'b101}: op = op_srliw;
                        {funct7_alt,  3'b101}: op = op_sraiw;
                    endcase
                end
                opc_lui:   op = op_lui;
                opc_auipc: op = op_auipc;
                opc_jal:   op = op_jal;
                opc_jalr: begin
                    if (funct3 == 3'b000) begin
                        op = op_jalr;
                    end
                end
                opc_branch: begin
                    case (funct3)
                        3'b000: op = op_beq;
                        3'b001: op = op_bne;
                        3'b100: op = op_blt;
                        3'b101: op = op_bge;
                        3'b110: op = op_bltu;
                        3'b111: op = op_bgeu;
                    endcase
                end
                opc_load: begin
                    case (funct3)
                        3'b000: op = op_lb;
                        3'b001: op = op_lh;
                        3'b010: op = op_lw;
                        3'b011: op = op_ld;
                        3'b100: op = op_lbu;
                        3'b101: op = op_lhu;
                        3'b110: op = op_lwu;
                    endcase
                end
                opc_store: begin
                    case (funct3)
                        3'b000: op = op_sb;
                        3'b001: op = op_sh;
                        3'b010: op = op_sw;
                        3'b011: op = op_sd;
                    endcase
                end
            endcase
        end
    end

    always_comb begin
        wen      = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (op)
            op_none: begin
                wen      = 1'b0;
                uses_rs1 = 1'b0;
            end
            op_lui, op_auipc, op_jal: uses_rs1 = 1'b0;
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                wen      = 1'b0;
                uses_rs2 = 1'b1;
            end
            op_sb, op_sh, op_sw, op_sd: wen = 1'b0;  // store data not tracked here
            op_add, op_sub, op_sll, op_slt, op_sltu,
            op_xor, op_srl, op_sra, op_or, op_and,
            op_addw, op_subw, op_sllw, op_srlw, op_sraw: uses_rs2 = 1'b1;
        endcase
    end

endmodule

/* logic/operand_select.sv */
// immediate generation and ALU operand/mode selection
`timescale 1ns/1ps

module operand_select (
    input  decode_pkg::dec_op_e       op,
    input  riscv_isa_pkg::inst_t      stage_inst,
    input  riscv_isa_pkg::word_t      stage_pc,
    input  riscv_isa_pkg::reg_idx_t   rs1,
    input  riscv_isa_pkg::reg_idx_t   rs2,
    input  riscv_isa_pkg::word_t      gpr [riscv_isa_pkg::reg_count],
    output riscv_isa_pkg::word_t      alu_a,
    output riscv_isa_pkg::word_t      alu_b,
    output decode_pkg::alu_mode_e     alu_mode
);
    import riscv_isa_pkg::*;
    import decode_pkg::*;

    word_t    src1;
    word_t    src2;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_u;
    word_t    imm_j;
    opa_sel_e a_sel;
    opb_sel_e b_sel;

    assign src1  = gpr[rs1];
    assign src2  = gpr[rs2];
    assign imm_i = {{(xlen-12){stage_inst[31]}}, stage_inst[31:20]};
    assign imm_s = {{(xlen-12){stage_inst[31]}}, stage_inst[31:25], stage_inst[11:7]};
    assign imm_u = {{(xlen-32){stage_inst[31]}}, stage_inst[31:12], 12'b0};
    assign imm_j = {{(xlen-21){stage_inst[31]}}, stage_inst[31], stage_inst[19:12],
                    stage_inst[20], stage_inst[30:21], 1'b0};

    always_comb begin
        case (op)
            op_slliw, op_srliw, op_sllw: a_sel = opa_src1_low_zext;
            op_srlw, op_sraiw, op_sraw:  a_sel = opa_src1_low_high;  // sign at bit 63
            op_none:                     a_sel = opa_zero;
            default:                     a_sel = opa_src1;
        endcase

        case (op)
            op_add, op_sub, op_slt, op_sltu, op_xor, op_or, op_and,
            op_addw, op_subw,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: b_sel = opb_src2;
            op_sll, op_srl, op_sra:                      b_sel = opb_src2_sh6;
            op_sllw, op_srlw, op_sraw:                   b_sel = opb_src2_sh5;
            op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
            op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
            op_jalr, op_addiw:                           b_sel = opb_imm_i;
            op_sb, op_sh, op_sw, op_sd:                  b_sel = opb_imm_s;
            op_auipc:                                    b_sel = opb_imm_u;
            op_jal:                                      b_sel = opb_imm_j;
            op_slli, op_srli, op_srai:                   b_sel = opb_shamt6;
            op_slliw, op_srliw, op_sraiw:                b_sel = opb_shamt5;
            default:                                     b_sel = opb_zero;
        endcase

        case (op)
            op_sub, op_subw,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: alu_mode = alu_sub;
            op_slt, op_slti:                             alu_mode = alu_slt;
            op_sltu, op_sltiu:                           alu_mode = alu_sltu;
            op_and, op_andi:                             alu_mode = alu_and;
            op_or, op_ori:                               alu_mode = alu_or;
            op_xor, op_xori:                             alu_mode = alu_xor;
            op_sll, op_slli, op_sllw, op_slliw:          alu_mode = alu_sll;
            op_srl, op_srli, op_srlw, op_srliw:          alu_mode = alu_srl;
            op_sra, op_srai, op_sraw, op_sraiw:          alu_mode = alu_sra;
            default:                                     alu_mode = alu_add;
        endcase
    end

    always_comb begin
        case (a_sel)
            opa_src1:          alu_a = src1;
            opa_src1_low_zext: alu_a = {32'b0, src1[31:0]};
            opa_src1_low_high: alu_a = {src1[31:0], 32'b0};
            default:           alu_a = '0;
        endcase
        if (op == op_lui) begin
            alu_a = imm_u;     // lui result passes on A
        end else if (op == op_auipc || op == op_jal) begin
            alu_a = stage_pc;
        end
    end

    always_comb begin
        case (b_sel)
            opb_src2:     alu_b = src2;
            opb_src2_sh6: alu_b = {{(xlen-6){1'b0}}, src2[5:0]};
            opb_src2_sh5: alu_b = {{(xlen-5){1'b0}}, src2[4:0]};
            opb_imm_i:    alu_b = imm_i;
            opb_imm_s:    alu_b = imm_s;
            opb_imm_u:    alu_b = imm_u;
            opb_imm_j:    alu_b = imm_j;
            opb_shamt6:   alu_b = {{(xlen-6){1'b0}}, stage_inst[25:20]};
            opb_shamt5:   alu_b = {{(xlen-5){1'b0}}, stage_inst[24:20]};
            default:      alu_b = '0;
        endcase
    end

endmodule

/* logic/decode_stage.sv */
// RV64I decode stage: stage register, decoder and ALU operand build
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid_IF_ID,
    output logic                      ready_IF_ID,
    input  riscv_isa_pkg::word_t      pc_IF_ID,
    input  riscv_isa_pkg::inst_t      inst_IF_ID,
    input  riscv_isa_pkg::word_t      gpr [riscv_isa_pkg::reg_count],
    input  logic [riscv_isa_pkg::reg_count-1:0] gpr_busy,
    output riscv_isa_pkg::word_t      alu_a,
    output riscv_isa_pkg::word_t      alu_b,
    output decode_pkg::alu_mode_e     alu_mode,
    output riscv_isa_pkg::reg_idx_t   rd,
    output logic                      wen,
    output decode_pkg::dec_op_e       op,
    output logic                      valid_ID_EX,
    input  logic                      ready_ID_EX,
    output riscv_isa_pkg::word_t      pc_ID_EX,
    output riscv_isa_pkg::inst_t      inst_ID_EX
);

    logic                    stage_valid;
    riscv_isa_pkg::word_t    stage_pc;
    riscv_isa_pkg::inst_t    stage_inst;
    riscv_isa_pkg::reg_idx_t rs1;
    riscv_isa_pkg::reg_idx_t rs2;
    logic                    uses_rs1;
    logic                    uses_rs2;

    id_stage_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .valid_IF_ID (valid_IF_ID),
        .pc_IF_ID    (pc_IF_ID),
        .inst_IF_ID  (inst_IF_ID),
        .ready_ID_EX (ready_ID_EX),
        .gpr_busy    (gpr_busy),
        .rs1         (rs1),
        .rs2         (rs2),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2),
        .stage_valid (stage_valid),
        .stage_pc    (stage_pc),
        .stage_inst  (stage_inst),
        .ready_IF_ID (ready_IF_ID),
        .valid_ID_EX (valid_ID_EX)
    );

    inst_decoder u_dec (
        .stage_valid (stage_valid),
        .stage_inst  (stage_inst),
        .op          (op),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .wen         (wen),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2)
    );

    operand_select u_opsel (
        .op         (op),
        .stage_inst (stage_inst),
        .stage_pc   (stage_pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .gpr        (gpr),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_mode   (alu_mode)
    );

    assign pc_ID_EX   = stage_pc;    // valid only with valid_ID_EX
    assign inst_ID_EX = stage_inst;

endmodule

/* verification/decode_stage_chk.sv */
// handshake assertions for the decode stage attached by bind
`timescale 1ns/1ps

module decode_stage_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    valid_ID_EX,
    input logic                    ready_ID_EX,
    input logic                    ready_IF_ID,
    input riscv_isa_pkg::word_t    pc_ID_EX,
    input riscv_isa_pkg::inst_t    inst_ID_EX,
    input riscv_isa_pkg::word_t    alu_a,
    input riscv_isa_pkg::word_t    alu_b,
    input decode_pkg::alu_mode_e   alu_mode,
    input riscv_isa_pkg::reg_idx_t rd,
    input logic                    wen,
    input decode_pkg::dec_op_e     op
);
    import decode_pkg::*;

    int fail_count;  // failed assertions so far

    reset_idle: assert property (@(posedge clk) rst |=> !valid_ID_EX)
        else begin
            fail_count++;
            $error("valid_ID_EX high in the cycle after reset");
        end

    // no new fetch while execute pushes back
    bp_blocks_fetch: assert property (@(posedge clk) disable iff (rst)
        (valid_ID_EX && !ready_ID_EX) |-> !ready_IF_ID)
        else begin
            fail_count++;
            $error("ready_IF_ID high under back-pressure");
        end

    bp_holds_outputs: assert property (@(posedge clk) disable iff (rst)
        (valid_ID_EX && !ready_ID_EX) |=> (valid_ID_EX && $stable(pc_ID_EX)
            && $stable(inst_ID_EX) && $stable(alu_a) && $stable(alu_b)
            && $stable(alu_mode) && $stable(rd) && $stable(wen) && $stable(op)))
        else begin
            fail_count++;
            $error("outputs changed under back-pressure");
        end

    wen_has_op: assert property (@(posedge clk) disable iff (rst)
        wen |-> (op != op_none))
        else begin
            fail_count++;
            $error("wen high with no operation");
        end

endmodule

/* verification/tb_decode_stage.sv */
// testbench for the RV64I decode stage with directed, hazard and random streams
`timescale 1ns/1ps

module tb_decode_stage;
    import riscv_isa_pkg::*;
    import decode_pkg::*;

    logic          clk;
    logic          rst;
    logic          valid_IF_ID;
    logic          ready_IF_ID;
    word_t         pc_IF_ID;
    inst_t         inst_IF_ID;
    word_t         gpr [reg_count];
    logic [31:0]   gpr_busy;
    word_t         alu_a;
    word_t         alu_b;
    alu_mode_e     alu_mode;
    reg_idx_t      rd;
    logic          wen;
    dec_op_e       op;
    logic          valid_ID_EX;
    logic          ready_ID_EX;
    word_t         pc_ID_EX;
    inst_t         inst_ID_EX;

    logic          bp_on;
    logic          lat_on;
    int            cyc;
    word_t         q_pc[$];
    inst_t         q_inst[$];
    word_t         q_a[$];
    word_t         q_b[$];
    alu_mode_e     q_mode[$];
    dec_op_e       q_op[$];
    logic          q_wen[$];
    int            q_cyc[$];

    decode_stage uut (.*);

    bind decode_stage decode_stage_chk chk (
        .clk(clk), .rst(rst), .valid_ID_EX(valid_ID_EX), .ready_ID_EX(ready_ID_EX),
        .ready_IF_ID(ready_IF_ID), .pc_ID_EX(pc_ID_EX), .inst_ID_EX(inst_ID_EX),
        .alu_a(alu_a), .alu_b(alu_b), .alu_mode(alu_mode), .rd(rd), .wen(wen), .op(op)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    always @(posedge clk) begin
        #1;
        ready_ID_EX = bp_on ? ($urandom() % 3 != 0) : 1'b1;
    end

    task automatic stop_fail(string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic mismatch(string name, logic [63:0] got, logic [63:0] exp);
        $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        stop_fail("output value check failed");
    endtask

    function automatic logic [6:0] opcode_of(dec_op_e o);
        if (o inside {[op_add:op_and]}) return 7'h33;
        if (o inside {[op_addi:op_srai]}) return 7'h13;
        if (o inside {[op_addw:op_sraw]}) return 7'h3b;
        if (o inside {[op_addiw:op_sraiw]}) return 7'h1b;
        if (o inside {[op_beq:op_bgeu]}) return 7'h63;
        if (o inside {[op_lb:op_lwu]}) return 7'h03;
        if (o inside {[op_sb:op_sd]}) return 7'h23;
        case (o)
            op_lui:   return 7'h37;
            op_auipc: return 7'h17;
            op_jal:   return 7'h6f;
            default:  return 7'h67;
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(dec_op_e o);
        case (o)
            op_sll, op_slli, op_sllw, op_slliw, op_bne, op_lh, op_sh: return 3'd1;
            op_slt, op_slti, op_lw, op_sw:                            return 3'd2;
            op_sltu, op_sltiu, op_ld, op_sd:                          return 3'd3;
            op_xor, op_xori, op_blt, op_lbu:                          return 3'd4;
            op_srl, op_sra, op_srli, op_srai, op_srlw, op_sraw,
            op_srliw, op_sraiw, op_bge, op_lhu:                       return 3'd5;
            op_or, op_ori, op_bltu, op_lwu:                           return 3'd6;
            op_and, op_andi, op_bgeu:                                 return 3'd7;
            default:                                                  return 3'd0;
        endcase
    endfunction

    // random fields overlaid with the fixed opcode and funct bits of the operation
    function automatic inst_t encode(dec_op_e o, inst_t r);
        inst_t i;
        logic  alt;
        i = r;
        alt = o inside {op_sub, op_sra, op_srai, op_subw, op_sraw, op_sraiw};
        i[6:0] = opcode_of(o);
        if (!(o inside {op_lui, op_auipc, op_jal})) begin
            i[14:12] = funct3_of(o);
        end
        if (o inside {[op_add:op_and], [op_addw:op_sraw], [op_slliw:op_sraiw]}) begin
            i[31:25] = alt ? 7'h20 : 7'h00;
        end
        if (o inside {[op_slli:op_srai]}) begin
            i[31:26] = alt ? 6'h10 : 6'h00;
        end
        return i;
    endfunction

    function automatic inst_t with_regs(inst_t i, reg_idx_t r1, reg_idx_t r2);
        inst_t t;
        t = i;
        t[19:15] = r1;
        t[24:20] = r2;
        return t;
    endfunction

    task automatic push_expected(dec_op_e o, inst_t i, word_t pc);
        word_t     s1;
        word_t     s2;
        word_t     a;
        word_t     b;
        alu_mode_e m;
        s1 = gpr[i[19:15]];
        s2 = gpr[i[24:20]];
        case (o)
            op_lui:                      a = {{32{i[31]}}, i[31:12], 12'h000};
            op_auipc, op_jal:            a = pc;
            op_slliw, op_srliw, op_sllw: a = {32'h0, s1[31:0]};
            op_srlw, op_sraiw, op_sraw:  a = {s1[31:0], 32'h0};
            op_none:                     a = '0;
            default:                     a = s1;
        endcase
        b = '0;
        if (o inside {[op_add:op_and], op_addw, op_subw, [op_beq:op_bgeu]}) b = s2;
        if (o inside {op_sll, op_srl, op_sra}) b = {58'h0, s2[5:0]};
        if (o inside {op_sllw, op_srlw, op_sraw}) b = {59'h0, s2[4:0]};
        if (o inside {[op_addi:op_andi], [op_lb:op_lwu], op_jalr, op_addiw}) begin
            b = {{52{i[31]}}, i[31:20]};
        end
        if (o inside {[op_sb:op_sd]}) b = {{52{i[31]}}, i[31:25], i[11:7]};
        if (o == op_auipc) b = {{32{i[31]}}, i[31:12], 12'h000};
        if (o == op_jal) b = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        if (o inside {[op_slli:op_srai]}) b = {58'h0, i[25:20]};
        if (o inside {[op_slliw:op_sraiw]}) b = {59'h0, i[24:20]};
        case (o)
            op_sub, op_subw, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: m = alu_sub;
            op_slt, op_slti:                    m = alu_slt;
            op_sltu, op_sltiu:                  m = alu_sltu;
            op_and, op_andi:                    m = alu_and;
            op_or, op_ori:                      m = alu_or;
            op_xor, op_xori:                    m = alu_xor;
            op_sll, op_slli, op_sllw, op_slliw: m = alu_sll;
            op_srl, op_srli, op_srlw, op_srliw: m = alu_srl;
            op_sra, op_srai, op_sraw, op_sraiw: m = alu_sra;
            default:                            m = alu_add;
        endcase
        q_pc.push_back(pc);
        q_inst.push_back(i);
        q_a.push_back(a);
        q_b.push_back(b);
        q_mode.push_back(m);
        q_op.push_back(o);
        q_wen.push_back(!(o inside {[op_beq:op_bgeu], [op_sb:op_sd], op_none}));
        q_cyc.push_back(cyc);
    endtask

    // holds the instruction on the fetch side until the stage takes it
    task automatic send(inst_t i, word_t pc, dec_op_e o);
        int tries;
        bit taken;
        valid_IF_ID = 1'b1;
        pc_IF_ID    = pc;
        inst_IF_ID  = i;
        tries = 0;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            if (ready_IF_ID) begin
                push_expected(o, i, pc);
                taken = 1'b1;
            end
            @(posedge clk);
            #1;
            tries++;
            if (tries > 200) stop_fail("timeout: decode stage never accepted an instruction");
        end
    endtask

    task automatic drain();
        int tries;
        tries = 0;
        while (q_pc.size() != 0) begin
            @(posedge clk);
            #1;
            tries++;
            if (tries > 500) stop_fail("timeout: issued instructions never left the stage");
        end
    endtask

    always @(negedge clk) begin
        if (uut.chk.fail_count != 0) begin
            stop_fail("a bound handshake assertion failed");
        end
    end

    always @(negedge clk) begin
        if (!rst && valid_ID_EX && ready_ID_EX) begin
            if (q_pc.size() == 0) begin
                stop_fail("stage delivered an instruction that was never issued");
            end else begin
                assert (pc_ID_EX == q_pc[0]) else mismatch("pc_ID_EX", pc_ID_EX, q_pc[0]);
                assert (inst_ID_EX == q_inst[0])
                    else mismatch("inst_ID_EX", 64'(inst_ID_EX), 64'(q_inst[0]));
                assert (op == q_op[0]) else mismatch("op", 64'(op), 64'(q_op[0]));
                assert (rd == q_inst[0][11:7])
                    else mismatch("rd", 64'(rd), 64'(q_inst[0][11:7]));
                assert (wen == q_wen[0]) else mismatch("wen", 64'(wen), 64'(q_wen[0]));
                assert (alu_a == q_a[0]) else mismatch("alu_a", alu_a, q_a[0]);
                assert (alu_b == q_b[0]) else mismatch("alu_b", alu_b, q_b[0]);
                assert (alu_mode == q_mode[0])
                    else mismatch("alu_mode", 64'(alu_mode), 64'(q_mode[0]));
                if (lat_on) begin
                    assert (cyc == q_cyc[0] + 1)
                        else stop_fail("instruction did not leave one cycle after acceptance");
                end
                void'(q_pc.pop_front());
                void'(q_inst.pop_front());
                void'(q_a.pop_front());
                void'(q_b.pop_front());
                void'(q_mode.pop_front());
                void'(q_op.pop_front());
                void'(q_wen.pop_front());
                void'(q_cyc.pop_front());
            end
        end
    end

    initial begin
        #400000;
        stop_fail("timeout: simulation ran past its time limit");
    end

    initial begin
        dec_op_e     o;
        word_t       pc;
        int          k;
        void'($urandom(34446));
        rst = 1'b1;
        valid_IF_ID = 1'b0;
        pc_IF_ID = '0;
        inst_IF_ID = '0;
        gpr_busy = '0;
        ready_ID_EX = 1'b1;
        bp_on = 1'b0;
        lat_on = 1'b0;
        for (int r = 0; r < reg_count; r++) begin
            gpr[r] = {$urandom(), $urandom()};
        end
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        assert (!valid_ID_EX && !wen && ready_IF_ID)
            else stop_fail("stage not idle after reset");
        @(posedge clk);
        #1;

        // every kept operation back to back without stalls
        lat_on = 1'b1;
        pc = 64'h1000;
        for (k = 1; k <= int'(op_sd); k++) begin
            o = dec_op_e'(k);
            send(encode(o, $urandom()), pc, o);
            pc = pc + 64'd4;
        end
        send(32'h02c58533, pc, op_none);           // mul
        send(32'h00000073, pc + 64'd4, op_none);   // ecall
        valid_IF_ID = 1'b0;
        drain();
        lat_on = 1'b0;

        // busy rs1 of an add and busy rs2 of a branch
        for (k = 0; k < 2; k++) begin
            o = (k == 0) ? op_add : op_bne;
            gpr_busy = (k == 0) ? 32'h0000_0020 : 32'h0000_0200;
            send(with_regs(encode(o, $urandom()), 5'd5, 5'd9), 64'h2000, o);
            valid_IF_ID = 1'b0;
            repeat (4) begin
                @(negedge clk);
                assert (!valid_ID_EX && !ready_IF_ID)
                    else stop_fail("busy source register did not stall the stage");
                @(posedge clk);
                #1;
            end
            gpr_busy = '0;
            drain();
        end

        // busy rs2 field of a store and of an addi is ignored
        for (k = 0; k < 2; k++) begin
            o = (k == 0) ? op_sd : op_addi;
            gpr_busy = 32'h0000_0200;
            send(with_regs(encode(o, $urandom()), 5'd3, 5'd9), 64'h3000, o);
            valid_IF_ID = 1'b0;
            @(negedge clk);
            assert (valid_ID_EX) else stop_fail("stage stalled on an unused rs2 field");
            @(posedge clk);
            #1;
            drain();
            gpr_busy = '0;
        end

        // random stream under back-pressure
        bp_on = 1'b1;
        pc = 64'h8000;
        repeat (300) begin
            k = 1 + int'($urandom() % 32'(op_sd));
            o = dec_op_e'(k);
            send(encode(o, $urandom()), pc, o);
            pc = pc + 64'd4;
        end
        valid_IF_ID = 1'b0;
        drain();
        bp_on = 1'b0;

        if (uut.chk.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* filelist.f */
logic/riscv_isa_pkg.sv
logic/decode_pkg.sv
logic/id_stage_ctrl.sv
logic/inst_decoder.sv
logic/operand_select.sv
logic/decode_stage.sv
verification/decode_stage_chk.sv
verification/tb_decode_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_decode_stage \
    -o sim_decode_stage \
    && ./obj_dir/sim_decode_stage > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "No errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
